// ==== files.f ====
hw/mini_mcu_pkg.sv
hw/obi_if.sv
hw/system_bus.sv
hw/memory_subsystem.sv
hw/ao_peripheral_subsystem.sv
hw/mini_mcu.sv
verif/tb_mini_mcu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mini_mcu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module tb_mini_mcu -f files.f

out=$(./obj_dir/Vtb_mini_mcu)
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
  exit 0
else
  exit 1
fi

// ==== verif/tb_mini_mcu.sv ====
////////////////////////////////////////////////////////////
// testbench for mini_mcu, plays the OBI master
// assumes NUM_BYTES = 1024 and RAM filled before random reads
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_mini_mcu;

  localparam int unsigned NUM_BYTES   = 1024;
  localparam int unsigned NUM_WORDS   = NUM_BYTES / 4;
  localparam int unsigned IDX_W       = $clog2(NUM_WORDS);
  localparam int unsigned N_RAND      = 200;
  localparam int unsigned TEST_CYCLES = 2 + 4 + NUM_WORDS + N_RAND + 40;
  localparam int unsigned CLK_PERIOD  = 100;
  localparam logic [31:0] PERIPH_BASE = 32'h2000_0000;

  logic        clk_i;
  logic        rst_n_i;
  logic        boot_select_i;
  logic        bus_req_i;
  logic        bus_gnt_o;
  logic [31:0] bus_addr_i;
  logic        bus_we_i;
  logic [3:0]  bus_be_i;
  logic [31:0] bus_wdata_i;
  logic        bus_rvalid_o;
  logic [31:0] bus_rdata_o;
  logic [31:0] gpio_i;
  logic [31:0] gpio_o;
  logic [31:0] exit_value_o;
  logic        exit_valid_o;

  // reference model state
  logic [31:0] ram_model [NUM_WORDS];
  logic [31:0] gpio_model;
  logic [31:0] exit_value_model;
  logic        exit_valid_model;
  logic        nxt_rvalid;
  logic [31:0] nxt_rdata;
  logic        exp_rvalid;
  logic [31:0] exp_rdata;
  logic [31:0] exp_gpio;
  logic [31:0] exp_exit_value;
  logic        exp_exit_valid;
  logic [15:0] lfsr_q;
  logic [31:0] rnd;
  int          value_errs;
  int          other_errs;

  mini_mcu #(
    .NUM_BYTES(NUM_BYTES)
  ) mini_mcu_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .boot_select_i (boot_select_i),
    .bus_req_i     (bus_req_i),
    .bus_gnt_o     (bus_gnt_o),
    .bus_addr_i    (bus_addr_i),
    .bus_we_i      (bus_we_i),
    .bus_be_i      (bus_be_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_rvalid_o  (bus_rvalid_o),
    .bus_rdata_o   (bus_rdata_o),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o)
  );

  always begin
    #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_v,
                                              input logic [31:0] new_v, input logic [3:0] be);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] periph_read(input logic [4:0] off);
    case (off)
      5'h00:   return {31'b0, exit_valid_model};
      5'h04:   return exit_value_model;
      5'h08:   return {31'b0, boot_select_i};
      5'h0C:   return gpio_model;
      5'h10:   return gpio_i;
      default: return '0;
    endcase
  endfunction

  // one request per call, back to back when called in a row
  task automatic drive_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0]      rd;
    logic [IDX_W-1:0] idx;
    @(posedge clk_i);
    #1;
    gpio_i      = rand_bits(32);
    bus_req_i   = 1'b1;
    bus_addr_i  = addr;
    bus_we_i    = we;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    rd          = '0;
    idx         = addr[IDX_W+1:2];
    if (addr[31:28] == 4'h0 && addr < NUM_BYTES) begin
      if (we) begin
        ram_model[idx] = merge_bytes(ram_model[idx], wdata, be);
      end else begin
        rd = ram_model[idx];
      end
    end else if (addr[31:28] == 4'h2) begin
      if (!we) begin
        rd = periph_read(addr[4:0]);
      end else begin
        case (addr[4:0])
          5'h00:   exit_valid_model = exit_valid_model | wdata[0];
          5'h04:   exit_value_model = merge_bytes(exit_value_model, wdata, be);
          5'h0C:   gpio_model = merge_bytes(gpio_model, wdata, be);
          default: ;
        endcase
      end
    end
    nxt_rvalid = 1'b1;
    nxt_rdata  = rd;
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #1;
    bus_req_i  = 1'b0;
    bus_we_i   = 1'b0;
    nxt_rvalid = 1'b0;
    nxt_rdata  = '0;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    value_errs++;
    $display("[FAIL] %s expected %08h got %08h", name, exp_v, got_v);
  endtask

  task automatic report_response(input logic expected);
    other_errs++;
    if (expected) begin
      $display("no response one cycle after an accepted request");
    end else begin
      $display("response without a request in the previous cycle");
    end
  endtask

  task automatic print_summary();
    $display("summary: %0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
  endtask

  // expected response and outputs, one cycle behind the request
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_rvalid     <= 1'b0;
      exp_rdata      <= '0;
      exp_gpio       <= '0;
      exp_exit_value <= '0;
      exp_exit_valid <= 1'b0;
    end else begin
      exp_rvalid     <= nxt_rvalid;
      exp_rdata      <= nxt_rdata;
      exp_gpio       <= gpio_model;
      exp_exit_value <= exit_value_model;
      exp_exit_valid <= exit_valid_model;
    end
  end

  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i) bus_gnt_o == bus_req_i)
    else report_mismatch("bus_gnt_o", {31'b0, $sampled(bus_req_i)},
                         {31'b0, $sampled(bus_gnt_o)});
  a_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i) bus_rvalid_o == exp_rvalid)
    else report_response($sampled(exp_rvalid));
  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_rvalid |-> bus_rdata_o == exp_rdata)
    else report_mismatch("bus_rdata_o", $sampled(exp_rdata), $sampled(bus_rdata_o));
  a_gpio: assert property (@(posedge clk_i) disable iff (!rst_n_i) gpio_o == exp_gpio)
    else report_mismatch("gpio_o", $sampled(exp_gpio), $sampled(gpio_o));
  a_exit_value: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_value_o == exp_exit_value)
    else report_mismatch("exit_value_o", $sampled(exp_exit_value), $sampled(exit_value_o));
  a_exit_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exit_valid_o == exp_exit_valid)
    else report_mismatch("exit_valid_o", {31'b0, $sampled(exp_exit_valid)},
                         {31'b0, $sampled(exit_valid_o)});

  initial begin
    #((TEST_CYCLES + 50) * CLK_PERIOD);
    other_errs++;
    $display("timeout: the test sequence did not finish in time");
    print_summary();
    $finish;
  end

  initial begin
    clk_i            = 1'b0;
    rst_n_i          = 1'b0;
    boot_select_i    = 1'b0;
    bus_req_i        = 1'b0;
    bus_addr_i       = '0;
    bus_we_i         = 1'b0;
    bus_be_i         = '0;
    bus_wdata_i      = '0;
    gpio_i           = '0;
    gpio_model       = '0;
    exit_value_model = '0;
    exit_valid_model = 1'b0;
    nxt_rvalid       = 1'b0;
    nxt_rdata        = '0;
    lfsr_q           = 16'd56627;
    value_errs       = 0;
    other_errs       = 0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    repeat (4) idle_cycle();

    // fill the whole RAM, then random traffic
    for (int w = 0; w < int'(NUM_WORDS); w++) begin
      rnd = rand_bits(32);
      drive_req(32'(w * 4), 1'b1, 4'hF, rnd);
    end
    for (int i = 0; i < int'(N_RAND); i++) begin
      logic             we;
      logic [3:0]       be;
      logic [IDX_W-1:0] idx;
      rnd = rand_bits(1);
      we  = rnd[0];
      rnd = rand_bits(IDX_W);
      idx = rnd[IDX_W-1:0];
      rnd = rand_bits(4);
      be  = rnd[3:0];
      rnd = rand_bits(32);
      drive_req(32'(idx) << 2, we, be, rnd);
    end

    drive_req(PERIPH_BASE + 32'h0C, 1'b1, 4'hF, 32'hA5A5_1234);
    drive_req(PERIPH_BASE + 32'h0C, 1'b1, 4'b0110, rand_bits(32));
    drive_req(PERIPH_BASE + 32'h0C, 1'b0, 4'hF, '0);
    drive_req(PERIPH_BASE + 32'h04, 1'b1, 4'b0101, rand_bits(32));
    drive_req(PERIPH_BASE + 32'h04, 1'b0, 4'hF, '0);
    drive_req(PERIPH_BASE + 32'h00, 1'b1, 4'hF, 32'h1);
    drive_req(PERIPH_BASE + 32'h00, 1'b1, 4'hF, 32'h0);
    drive_req(PERIPH_BASE + 32'h00, 1'b0, 4'hF, '0);
    boot_select_i = 1'b1;
    drive_req(PERIPH_BASE + 32'h08, 1'b0, 4'hF, '0);
    // boot select changes while the GPIO_IN read is in flight
    drive_req(PERIPH_BASE + 32'h10, 1'b0, 4'hF, '0);
    boot_select_i = 1'b0;
    drive_req(PERIPH_BASE + 32'h08, 1'b0, 4'hF, '0);
    drive_req(PERIPH_BASE + 32'h10, 1'b0, 4'hF, '0);

    // unmapped accesses
    drive_req(32'h1000_0000, 1'b1, 4'hF, 32'hDEAD_BEEF);
    drive_req(32'h1000_0000, 1'b0, 4'hF, '0);
    drive_req(32'h0000_0400, 1'b1, 4'hF, 32'hCAFE_F00D);
    drive_req(32'h0000_0400, 1'b0, 4'hF, '0);
    drive_req(32'h0FFF_FFFC, 1'b1, 4'hF, 32'h1234_5678);
    drive_req(32'h0000_0000, 1'b0, 4'hF, '0);
    drive_req(32'h0000_03FC, 1'b0, 4'hF, '0);
    drive_req(PERIPH_BASE + 32'h14, 1'b1, 4'hF, 32'hFFFF_FFFF);
    drive_req(PERIPH_BASE + 32'h14, 1'b0, 4'hF, '0);
    drive_req(PERIPH_BASE + 32'h1C, 1'b1, 4'hF, 32'hFFFF_FFFF);
    drive_req(PERIPH_BASE + 32'h0C, 1'b0, 4'hF, '0);
    drive_req(PERIPH_BASE + 32'h04, 1'b0, 4'hF, '0);
    repeat (3) idle_cycle();

    print_summary();
    $finish;
  end

endmodule

// ==== hw/mini_mcu.sv ====
////////////////////////////////////////////////////////////
// mini MCU top, one external OBI master, no back-pressure
// GPIO has separate in and out ports, no pads
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module mini_mcu #(
  parameter int unsigned NUM_BYTES = 1024
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        boot_select_i,

  input  logic        bus_req_i,
  output logic        bus_gnt_o,
  input  logic [31:0] bus_addr_i,
  input  logic        bus_we_i,
  input  logic [3:0]  bus_be_i,
  input  logic [31:0] bus_wdata_i,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o,

  input  logic [31:0] gpio_i,
  output logic [31:0] gpio_o,

  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  obi_if ram_bus ();
  obi_if periph_bus ();

  system_bus #(
    .NUM_BYTES(NUM_BYTES)
  ) system_bus_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (bus_req_i),
    .gnt_o    (bus_gnt_o),
    .addr_i   (bus_addr_i),
    .we_i     (bus_we_i),
    .be_i     (bus_be_i),
    .wdata_i  (bus_wdata_i),
    .rvalid_o (bus_rvalid_o),
    .rdata_o  (bus_rdata_o),
    .ram_o    (ram_bus.master),
    .periph_o (periph_bus.master)
  );

  memory_subsystem #(
    .NUM_BYTES(NUM_BYTES)
  ) memory_subsystem_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus_i   (ram_bus.slave)
  );

  ao_peripheral_subsystem ao_peripheral_subsystem_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus_i         (periph_bus.slave),
    .boot_select_i (boot_select_i),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o)
  );

endmodule

// ==== hw/ao_peripheral_subsystem.sv ====
////////////////////////////////////////////////////////////
// always-on registers: exit flag/value, boot select, GPIO
// exit flag is sticky until reset, unlisted offsets read 0
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ao_peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  obi_if.slave        bus_i,
  input  logic        boot_select_i,
  input  logic [31:0] gpio_i,
  output logic [31:0] gpio_o,
  output logic [31:0] exit_value_o,
  output logic        exit_valid_o
);

  logic [4:0]  reg_off;
  logic        accept;
  logic        wr;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic        rvalid_q;
  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic [31:0] gpio_out_q;

  function automatic logic [31:0] be_merge(logic [31:0] old_v, logic [31:0] new_v,
                                           logic [3:0] be);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign bus_i.gnt = bus_i.req;
  assign accept    = bus_i.req & bus_i.gnt;
  assign wr        = accept & bus_i.we;
  assign reg_off   = bus_i.addr.periph.reg_off;

  always_comb begin
    rdata_d = '0;
    case (reg_off)
      EXIT_VALID_OFFSET:  rdata_d = {31'b0, exit_valid_q};
      EXIT_VALUE_OFFSET:  rdata_d = exit_value_q;
      BOOT_SELECT_OFFSET: rdata_d = {31'b0, boot_select_i};
      GPIO_OUT_OFFSET:    rdata_d = gpio_out_q;
      GPIO_IN_OFFSET:     rdata_d = gpio_i;
      default:            rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      gpio_out_q   <= '0;
      rvalid_q     <= 1'b0;
    end else begin
      rvalid_q <= accept;
      if (wr && reg_off == EXIT_VALUE_OFFSET) begin
        exit_value_q <= be_merge(exit_value_q, bus_i.wdata, bus_i.be);
      end
      if (wr && reg_off == GPIO_OUT_OFFSET) begin
        gpio_out_q <= be_merge(gpio_out_q, bus_i.wdata, bus_i.be);
      end
      // set only, never cleared by software
      if (wr && reg_off == EXIT_VALID_OFFSET && bus_i.wdata[0]) begin
        exit_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= bus_i.we ? '0 : rdata_d;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign gpio_o       = gpio_out_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  a_exit_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> !$fell(exit_valid_q));

endmodule

// ==== hw/memory_subsystem.sv ====
////////////////////////////////////////////////////////////
// on-chip RAM, NUM_BYTES must be a power of two
// contents are not cleared by reset
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module memory_subsystem #(
  parameter int unsigned NUM_BYTES = 1024
) (
  input  logic clk_i,
  input  logic rst_n_i,
  obi_if.slave bus_i
);

  localparam int unsigned NUM_WORDS = NUM_BYTES / 4;
  localparam int unsigned IDX_W     = $clog2(NUM_WORDS);

  logic [31:0]      mem_q [NUM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             accept;
  logic             rvalid_q;
  logic [31:0]      rdata_q;

  assign bus_i.gnt = bus_i.req;
  assign accept    = bus_i.req & bus_i.gnt;
  assign idx       = bus_i.addr.mem.word_idx[IDX_W-1:0];

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (accept && bus_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (bus_i.be[b]) begin
          mem_q[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // write responses return zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= bus_i.we ? '0 : mem_q[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;

  // range is checked by the bus decoder
  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_i.req |-> (bus_i.addr.mem.word_idx < 26'(NUM_WORDS)));

endmodule

// ==== hw/system_bus.sv ====
////////////////////////////////////////////////////////////
// single-master bus: RAM, always-on peripherals, unmapped
// no back-pressure, every response comes one cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module system_bus
  import mini_mcu_pkg::*;
#(
  parameter int unsigned NUM_BYTES = 1024
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_i,
  output logic        gnt_o,
  input  bus_addr_u   addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  obi_if.master       ram_o,
  obi_if.master       periph_o
);

  localparam int unsigned NUM_WORDS = NUM_BYTES / 4;

  logic ram_hit;
  logic periph_hit;
  logic sel_ram_q;
  logic sel_periph_q;
  logic unmapped_rvalid_q;

  assign ram_hit    = (addr_i.mem.region == RAM_REGION) &&
                      (addr_i.mem.word_idx < 26'(NUM_WORDS));
  assign periph_hit = (addr_i.periph.region == PERIPH_REGION);

  // only the selected slave sees req
  assign ram_o.req    = req_i & ram_hit;
  assign periph_o.req = req_i & periph_hit;

  assign ram_o.addr  = addr_i;
  assign ram_o.we    = we_i;
  assign ram_o.be    = be_i;
  assign ram_o.wdata = wdata_i;

  assign periph_o.addr  = addr_i;
  assign periph_o.we    = we_i;
  assign periph_o.be    = be_i;
  assign periph_o.wdata = wdata_i;

  // unmapped requests are granted by the bus itself
  assign gnt_o = ram_hit ? ram_o.gnt : (periph_hit ? periph_o.gnt : req_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_ram_q         <= 1'b0;
      sel_periph_q      <= 1'b0;
      unmapped_rvalid_q <= 1'b0;
    end else begin
      sel_ram_q         <= ram_o.req & ram_o.gnt;
      sel_periph_q      <= periph_o.req & periph_o.gnt;
      unmapped_rvalid_q <= req_i & ~ram_hit & ~periph_hit;
    end
  end

  assign rvalid_o = sel_ram_q ? ram_o.rvalid :
                    (sel_periph_q ? periph_o.rvalid : unmapped_rvalid_q);
  assign rdata_o  = sel_ram_q ? ram_o.rdata : (sel_periph_q ? periph_o.rdata : '0);

  // the two slaves never answer in the same cycle
  a_one_responder: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ram_o.rvalid && periph_o.rvalid));

  a_ram_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram_o.rvalid |-> $past(ram_o.req && ram_o.gnt));

  a_periph_rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    periph_o.rvalid |-> $past(periph_o.req && periph_o.gnt));

endmodule

// ==== hw/obi_if.sv ====
////////////////////////////////////////////////////////////
// OBI link between the system bus and one slave
// gnt is expected to follow req in the same cycle
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface obi_if
  import mini_mcu_pkg::*;
();

  logic        req;
  logic        gnt;
  bus_addr_u   addr;
  logic        we;
  logic [3:0]  be;
  logic [31:0] wdata;
  logic        rvalid;
  logic [31:0] rdata;

  modport master (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

// ==== hw/mini_mcu_pkg.sv ====
////////////////////////////////////////////////////////////
// memory map and register offsets of the mini MCU
// regions are decoded from address bits 31:28 only
////////////////////////////////////////////////////////////

package mini_mcu_pkg;

  // region codes, compared with addr[31:28]
  localparam logic [3:0] RAM_REGION    = 4'h0;
  localparam logic [3:0] PERIPH_REGION = 4'h2;

  // always-on peripheral byte offsets
  localparam logic [4:0] EXIT_VALID_OFFSET  = 5'h00;
  localparam logic [4:0] EXIT_VALUE_OFFSET  = 5'h04;
  localparam logic [4:0] BOOT_SELECT_OFFSET = 5'h08;
  localparam logic [4:0] GPIO_OUT_OFFSET    = 5'h0C;
  localparam logic [4:0] GPIO_IN_OFFSET     = 5'h10;

  // one address word, seen by the RAM or by the peripheral block
  typedef union packed {
    struct packed {
      logic [3:0]  region;
      logic [25:0] word_idx;
      logic [1:0]  byte_off;
    } mem;
    struct packed {
      logic [3:0]  region;
      logic [22:0] rsvd;
      logic [4:0]  reg_off;
    } periph;
  } bus_addr_u;

endpackage
